/* compile.f */
+incdir+logic
logic/rtx_geom_pkg.sv
logic/rtx_scene_pkg.sv
logic/ray_if.sv
logic/scene_memory.sv
logic/ray_caster.sv
logic/ray_tracer.sv
logic/pixel_pack.sv
logic/rtx.sv
dv/tb_clock.sv
dv/rtx_assertions.sv
dv/rtx_tb.sv

/* dv/rtx_assertions.sv */
`timescale 1ns/1ns
`include "rtx_params.svh"

module rtx_assertions (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 pixel_valid,
  input logic                 frame_done,
  input rtx_geom_pkg::pix_h_t pixel_h,
  input rtx_geom_pkg::pix_v_t pixel_v
);

  // Output strobe comes out of reset low
  a_valid_after_reset: assert property (@(posedge clk) !rst_n |=> !pixel_valid)
    else $error("pixel_valid high in the cycle after reset");

  // One ray in flight, so pixels are at least two cycles apart
  a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
    pixel_valid |=> !pixel_valid)
    else $error("pixel_valid high on two consecutive cycles");

  // Coordinates stay inside the frame
  a_coord_range: assert property (@(posedge clk) disable iff (!rst_n)
    pixel_valid |-> (pixel_h < `RTX_WIDTH) && (pixel_v < `RTX_HEIGHT))
    else $error("pixel coordinates outside the frame");

  // End of frame only rides on the last pixel
  a_done_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
    frame_done |-> pixel_valid)
    else $error("frame_done without pixel_valid");

endmodule

bind rtx rtx_assertions u_assertions (
  .clk         (clk),
  .rst_n       (rst_n),
  .pixel_valid (pixel_valid),
  .frame_done  (frame_done),
  .pixel_h     (pixel_h),
  .pixel_v     (pixel_v)
);

/* dv/rtx_tb.sv */
`timescale 1ns/1ns
`include "rtx_params.svh"

module rtx_tb;
  import rtx_geom_pkg::*;
  import rtx_scene_pkg::*;

  // Random frames need up to 18 cycles per pixel and the fixed scenes far fewer
  // so the whole run stays near 15000 cycles
  localparam int CYCLE_LIMIT = 25000;
  localparam int NPIX = `RTX_WIDTH * `RTX_HEIGHT;
  localparam int CENTER = (`RTX_HEIGHT / 2) * `RTX_WIDTH + `RTX_WIDTH / 2;

  logic        clk;
  logic        rst_n;
  logic        scene_we;
  obj_idx_t    scene_addr;
  object_t     scene_wdata;
  obj_cnt_t    num_objs;
  logic        start;
  vec3_t       cam_pos;
  logic [15:0] rtx_pixel;
  pix_h_t      pixel_h;
  pix_v_t      pixel_v;
  logic        pixel_valid;
  logic        frame_done;

  // Copy of the loaded scene and frame settings for the model
  object_t     scene [`RTX_MAX_OBJS];
  int          cur_num;
  vec3_t       cur_cam;
  logic [15:0] got [NPIX];
  logic [31:0] lcg_state;
  int          cycle_count = 0;

  tb_clock #(.PERIOD_NS(100)) u_clock (.clk(clk));

  rtx u_dut (
    .clk(clk), .rst_n(rst_n), .scene_we(scene_we), .scene_addr(scene_addr),
    .scene_wdata(scene_wdata), .num_objs(num_objs), .start(start), .cam_pos(cam_pos),
    .rtx_pixel(rtx_pixel), .pixel_h(pixel_h), .pixel_v(pixel_v),
    .pixel_valid(pixel_valid), .frame_done(frame_done)
  );

  // Hard stop so a stuck DUT cannot hang the run
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: no end of test after %0d clock cycles", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic compare_values(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "first mismatch");
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper bits of the LCG are the better ones
  function automatic int rand_range(input int lo, input int hi);
    return lo + int'((lcg_next() >> 8) % (hi - lo + 1));
  endfunction

  function automatic vec3_t make_vec(input int x, input int y, input int z);
    vec3_t p;
    p.x = coord_t'(x);
    p.y = coord_t'(y);
    p.z = coord_t'(z);
    return p;
  endfunction

  function automatic object_t make_sphere(input vec3_t c, input int r, input logic [23:0] col);
    object_t o;
    o = '0;
    o.kind = SPHERE;
    o.color = col;
    o.geom.sphere.center = c;
    o.geom.sphere.radius = coord_t'(r);
    return o;
  endfunction

  function automatic object_t make_plane(input int axis, input int offs, input logic [23:0] col);
    object_t o;
    o = '0;
    o.kind = PLANE;
    o.color = col;
    o.geom.plane.axis = 2'(axis);
    o.geom.plane.offset = coord_t'(offs);
    return o;
  endfunction

  // Pack to RGB565 with red low and each channel rounded and clamped
  function automatic logic [15:0] pack_rgb565(input logic [23:0] c);
    int r5;
    int g6;
    int b5;
    r5 = (int'(c[23:16]) + 4) >> 3;
    g6 = (int'(c[15:8]) + 2) >> 2;
    b5 = (int'(c[7:0]) + 4) >> 3;
    r5 = (r5 > 31) ? 31 : r5;
    g6 = (g6 > 63) ? 63 : g6;
    b5 = (b5 > 31) ? 31 : b5;
    return {b5[4:0], g6[5:0], r5[4:0]};
  endfunction

  // Reference model giving the first hit colour and the number of objects looked at
  function automatic void trace_pixel(input int h, input int v,
                                      output logic [23:0] col, output int examined);
    longint lx, ly, lz, dx, dy, dz, b, ll, dd, rr, oc, dc, diff;
    object_t o;
    bit hit;
    dx = h - `RTX_WIDTH / 2;
    dy = v - `RTX_HEIGHT / 2;
    dz = `RTX_FOCAL;
    col = `RTX_BG_COLOR;
    examined = cur_num;
    for (int k = 0; k < cur_num; k++) begin
      o = scene[k];
      if (o.kind == SPHERE) begin
        lx = longint'(o.geom.sphere.center.x) - longint'(cur_cam.x);
        ly = longint'(o.geom.sphere.center.y) - longint'(cur_cam.y);
        lz = longint'(o.geom.sphere.center.z) - longint'(cur_cam.z);
        rr = longint'(o.geom.sphere.radius) * longint'(o.geom.sphere.radius);
        b = lx * dx + ly * dy + lz * dz;
        ll = lx * lx + ly * ly + lz * lz;
        dd = dx * dx + dy * dy + dz * dz;
        hit = (b > 0) && (b * b >= (ll - rr) * dd);
      end else begin
        // Axis code 3 has no direction and never hits
        case (o.geom.plane.axis)
          2'd0: begin
            oc = longint'(cur_cam.x);
            dc = dx;
          end
          2'd1: begin
            oc = longint'(cur_cam.y);
            dc = dy;
          end
          2'd2: begin
            oc = longint'(cur_cam.z);
            dc = dz;
          end
          default: begin
            oc = 0;
            dc = 0;
          end
        endcase
        diff = longint'(o.geom.plane.offset) - oc;
        hit = (diff != 0) && (dc != 0) && ((diff < 0) == (dc < 0));
      end
      if (hit) begin
        col = o.color;
        examined = k + 1;
        break;
      end
    end
  endfunction

  task automatic write_object(input int idx, input object_t obj);
    @(posedge clk);
    scene_we <= 1'b1;
    scene_addr <= obj_idx_t'(idx);
    scene_wdata <= obj;
    @(posedge clk);
    scene_we <= 1'b0;
    scene[idx] = obj;
  endtask

  task automatic set_frame(input int n, input vec3_t cam);
    @(posedge clk);
    num_objs <= obj_cnt_t'(n);
    cam_pos <= cam;
    cur_num = n;
    cur_cam = cam;
  endtask

  // Pulse start and check every pixel, its timing and frame_done
  task automatic collect_frame(input bit poke_start);
    logic [23:0] col;
    int examined;
    int n;
    int cyc;
    int prev;
    bit poked;
    bit finished;
    n = 0;
    cyc = 0;
    prev = 1;
    poked = 0;
    finished = 0;
    @(posedge clk);
    start <= 1'b1;
    while (!finished) begin
      @(posedge clk);
      cyc++;
      // A second start in mid-frame must be ignored
      if (poke_start && !poked && n == 50) begin
        start <= 1'b1;
        poked = 1;
      end else begin
        start <= 1'b0;
      end
      @(negedge clk);
      if (pixel_valid) begin
        trace_pixel(n % `RTX_WIDTH, n / `RTX_WIDTH, col, examined);
        compare_values(pixel_h, n % `RTX_WIDTH, "pixel_h");
        compare_values(pixel_v, n / `RTX_WIDTH, "pixel_v");
        compare_values(rtx_pixel, pack_rgb565(col), $sformatf("colour of pixel %0d", n));
        compare_values(cyc - prev, 2 * examined + 2, $sformatf("cycles before pixel %0d", n));
        compare_values(frame_done, n == NPIX - 1, $sformatf("frame_done at pixel %0d", n));
        got[n] = rtx_pixel;
        prev = cyc;
        n++;
        finished = frame_done;
      end else begin
        compare_values(frame_done, 0, "frame_done between pixels");
      end
    end
    repeat (10) begin
      @(negedge clk);
      compare_values(pixel_valid, 0, "pixel_valid after frame_done");
    end
  endtask

  // Scene present but num_objs is zero
  task automatic empty_scene_frame();
    write_object(0, make_sphere(make_vec(0, 0, 64), 40, 24'hff_ff_ff));
    set_frame(0, make_vec(0, 0, 0));
    collect_frame(0);
  endtask

  task automatic single_sphere_frame();
    int hits;
    hits = 0;
    write_object(0, make_sphere(make_vec(0, 0, 64), 24, 24'hff_80_07));
    set_frame(1, make_vec(0, 0, 0));
    collect_frame(0);
    for (int i = 0; i < NPIX; i++) begin
      hits += (got[i] == pack_rgb565(24'hff_80_07));
    end
    // Red clamps at 31 and green rounds up to 32
    compare_values(got[CENTER], 16'h0c1f, "saturated sphere colour at centre");
    compare_values(hits > 0 && hits < NPIX, 1, "sphere covers part of the frame");
  endtask

  // Overlap takes the lower slot and swapping slots swaps the winner
  task automatic sphere_priority_frames();
    object_t sa;
    object_t sb;
    sa = make_sphere(make_vec(-3, 0, 64), 20, 24'h10_e0_30);
    sb = make_sphere(make_vec(3, 0, 64), 20, 24'hc0_20_f0);
    write_object(0, sa);
    write_object(1, sb);
    set_frame(2, make_vec(0, 0, 0));
    collect_frame(0);
    compare_values(got[CENTER], pack_rgb565(sa.color), "overlap with first order");
    write_object(0, sb);
    write_object(1, sa);
    collect_frame(0);
    compare_values(got[CENTER], pack_rgb565(sb.color), "overlap with swapped order");
  endtask

  // Floor plane at y = 2 seen from a camera at y = -3
  task automatic plane_frame();
    write_object(0, make_plane(1, 2, 24'h40_ff_00));
    write_object(1, make_sphere(make_vec(0, 0, 64), 24, 24'hff_80_07));
    set_frame(2, make_vec(0, -3, 0));
    collect_frame(0);
    compare_values(got[NPIX - `RTX_WIDTH], pack_rgb565(24'h40_ff_00), "plane on bottom row");
    compare_values(got[0], pack_rgb565(`RTX_BG_COLOR), "background on top row");
  endtask

  task automatic random_frames();
    logic [23:0] col;
    for (int f = 0; f < 3; f++) begin
      for (int s = 0; s < `RTX_MAX_OBJS; s++) begin
        col = 24'(lcg_next());
        if (rand_range(0, 2) == 0) begin
          write_object(s, make_plane(rand_range(0, 3), rand_range(-20, 20), col));
        end else begin
          write_object(s, make_sphere(make_vec(rand_range(-40, 40), rand_range(-40, 40),
                                               rand_range(20, 120)), rand_range(4, 40), col));
        end
      end
      set_frame(rand_range(1, `RTX_MAX_OBJS),
                make_vec(rand_range(-10, 10), rand_range(-10, 10), rand_range(-10, 10)));
      collect_frame(1);
    end
  endtask

  initial begin
    lcg_state = 32'hc441_50d0;
    rst_n <= 1'b0;
    scene_we <= 1'b0;
    scene_addr <= '0;
    scene_wdata <= '0;
    num_objs <= '0;
    start <= 1'b0;
    cam_pos <= '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    empty_scene_frame();
    single_sphere_frame();
    sphere_priority_frames();
    plane_frame();
    random_frames();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  // Free-running clock, low at time zero
  initial begin
    clk = 1'b0;
  end

  always begin
    #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

/* logic/pixel_pack.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_pack (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ray_done,
  input  rtx_scene_pkg::rgb888_t color,
  input  rtx_geom_pkg::pix_h_t   pixel_h_in,
  input  rtx_geom_pkg::pix_v_t   pixel_v_in,
  input  logic                   frame_last,
  output logic [15:0]            rtx_pixel,
  output rtx_geom_pkg::pix_h_t   pixel_h,
  output rtx_geom_pkg::pix_v_t   pixel_v,
  output logic                   pixel_valid,
  output logic                   frame_done
);

  // Round 8 bits down to w bits and clamp at all ones
  function automatic logic [5:0] round_ch(input logic [7:0] c, input int unsigned w);
    logic [8:0] sum;
    logic [8:0] q;
    logic [8:0] max;
    sum = {1'b0, c} + (9'd1 << (7 - w));
    q   = sum >> (8 - w);
    max = (9'd1 << w) - 9'd1;
    return (q > max) ? max[5:0] : q[5:0];
  endfunction

  // Strobes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pixel_valid <= 1'b0;
      frame_done  <= 1'b0;
    end else begin
      pixel_valid <= ray_done;
      frame_done  <= ray_done && frame_last;
    end
  end

  // Blue high, green middle, red low
  always_ff @(posedge clk) begin
    if (ray_done) begin
      rtx_pixel <= {5'(round_ch(color.b, 5)), round_ch(color.g, 6), 5'(round_ch(color.r, 5))};
      pixel_h   <= pixel_h_in;
      pixel_v   <= pixel_v_in;
    end
  end

endmodule

`default_nettype wire

/* logic/ray_caster.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rtx_params.svh"

module ray_caster (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  logic                next_ray,
  input  rtx_geom_pkg::vec3_t cam_pos,
  output logic                frame_last,
  ray_if.caster               ray
);
  import rtx_geom_pkg::*;

  pix_h_t h_cnt;
  pix_v_t v_cnt;
  logic   active;
  logic   fire;
  logic   last_pix;
  vec3_t  dir_c;

  // Start only counts when idle, next_ray only while a frame runs
  assign fire = active ? next_ray : start;

  assign last_pix = (h_cnt == pix_h_t'(`RTX_WIDTH - 1)) &&
                    (v_cnt == pix_v_t'(`RTX_HEIGHT - 1));

  // Direction through the pixel, centred on the frame
  always_comb begin
    dir_c.x = coord_t'(h_cnt) - coord_t'(`RTX_WIDTH / 2);
    dir_c.y = coord_t'(v_cnt) - coord_t'(`RTX_HEIGHT / 2);
    dir_c.z = coord_t'(`RTX_FOCAL);
  end

  // Raster counters and the active flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active    <= 1'b0;
      h_cnt     <= '0;
      v_cnt     <= '0;
      ray.valid <= 1'b0;
    end else begin
      ray.valid <= fire;
      if (fire) begin
        if (last_pix) begin
          // Wrap for the next frame and go idle
          h_cnt  <= '0;
          v_cnt  <= '0;
          active <= 1'b0;
        end else begin
          active <= 1'b1;
          if (h_cnt == pix_h_t'(`RTX_WIDTH - 1)) begin
            h_cnt <= '0;
            v_cnt <= v_cnt + 1'b1;
          end else begin
            h_cnt <= h_cnt + 1'b1;
          end
        end
      end
    end
  end

  // Ray payload, captured with the strobe
  always_ff @(posedge clk) begin
    if (fire) begin
      ray.origin  <= cam_pos;
      ray.dir     <= dir_c;
      ray.pixel_h <= h_cnt;
      ray.pixel_v <= v_cnt;
      frame_last  <= last_pix;
    end
  end

endmodule

`default_nettype wire

/* logic/ray_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface ray_if;
  import rtx_geom_pkg::*;

  // Primary ray geometry
  vec3_t  origin;
  vec3_t  dir;
  // Pixel tag that travels with the ray
  pix_h_t pixel_h;
  pix_v_t pixel_v;
  // Single-cycle strobe, one per ray
  logic   valid;

  modport caster (
    output origin, dir, pixel_h, pixel_v, valid
  );

  modport tracer (
    input origin, dir, pixel_h, pixel_v, valid
  );

endinterface

`default_nettype wire

/* logic/ray_tracer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rtx_params.svh"

module ray_tracer (
  input  logic                    clk,
  input  logic                    rst_n,
  ray_if.tracer                   ray,
  input  rtx_scene_pkg::obj_cnt_t num_objs,
  output rtx_scene_pkg::obj_idx_t rd_idx,
  input  rtx_scene_pkg::object_t  rd_obj,
  input  logic                    frame_last_in,
  output logic                    ray_done,
  output rtx_scene_pkg::rgb888_t  color,
  output rtx_geom_pkg::pix_h_t    pixel_h_out,
  output rtx_geom_pkg::pix_v_t    pixel_v_out,
  output logic                    frame_last_out
);
  import rtx_geom_pkg::*;
  import rtx_scene_pkg::*;

  // FETCH presents rd_idx, TEST sees the object word
  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    TEST
  } state_t;

  state_t  state;
  vec3_t   ray_org;
  vec3_t   ray_dir;
  sphere_t sph;
  plane_t  pln;
  logic    sph_hit;
  logic    pln_hit;
  logic    obj_hit;
  logic    last_obj;

  // Exact 64-bit working values
  logic signed [63:0] lx, ly, lz;
  logic signed [63:0] dx, dy, dz;
  logic signed [63:0] b_dot, ll_dot, dd_dot, r_sq;
  logic signed [63:0] o_c, d_c, diff;

  // Two views of the same geometry word
  assign sph = rd_obj.geom.sphere;
  assign pln = rd_obj.geom.plane;

  // Sphere test, b > 0 and b^2 >= (L.L - r^2)(d.d)
  always_comb begin
    lx     = sph.center.x - ray_org.x;
    ly     = sph.center.y - ray_org.y;
    lz     = sph.center.z - ray_org.z;
    dx     = ray_dir.x;
    dy     = ray_dir.y;
    dz     = ray_dir.z;
    b_dot  = lx * dx + ly * dy + lz * dz;
    ll_dot = lx * lx + ly * ly + lz * lz;
    dd_dot = dx * dx + dy * dy + dz * dz;
    r_sq   = 64'(sph.radius) * 64'(sph.radius);
    sph_hit = (b_dot > 0) && (b_dot * b_dot >= (ll_dot - r_sq) * dd_dot);
  end

  // Plane test on the selected axis
  always_comb begin
    case (pln.axis)
      2'd0: begin
        o_c = ray_org.x;
        d_c = ray_dir.x;
      end
      2'd1: begin
        o_c = ray_org.y;
        d_c = ray_dir.y;
      end
      2'd2: begin
        o_c = ray_org.z;
        d_c = ray_dir.z;
      end
      default: begin
        // Unused axis code, zero direction means no hit
        o_c = '0;
        d_c = '0;
      end
    endcase
    diff    = pln.offset - o_c;
    // Plane lies ahead when distance and direction share a sign
    pln_hit = (diff != 0) && (d_c != 0) && (diff[63] == d_c[63]);
  end

  assign obj_hit = (rd_obj.kind == SPHERE) ? sph_hit : pln_hit;

  // Stop at num_objs, or at the top slot if num_objs is out of range
  assign last_obj = (obj_cnt_t'(rd_idx) + obj_cnt_t'(1) >= num_objs) ||
                    (rd_idx == obj_idx_t'(`RTX_MAX_OBJS - 1));

  // Control FSM
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= IDLE;
      ray_done <= 1'b0;
    end else begin
      ray_done <= 1'b0;
      case (state)
        IDLE: begin
          if (ray.valid) begin
            // Empty scene finishes at once with the background
            if (num_objs == '0) begin
              ray_done <= 1'b1;
            end else begin
              state <= FETCH;
            end
          end
        end
        FETCH: begin
          state <= TEST;
        end
        TEST: begin
          if (obj_hit || last_obj) begin
            ray_done <= 1'b1;
            state    <= IDLE;
          end else begin
            state <= FETCH;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Ray capture, object index and the chosen colour
  always_ff @(posedge clk) begin
    if (state == IDLE && ray.valid) begin
      ray_org        <= ray.origin;
      ray_dir        <= ray.dir;
      pixel_h_out    <= ray.pixel_h;
      pixel_v_out    <= ray.pixel_v;
      frame_last_out <= frame_last_in;
      rd_idx         <= '0;
      color          <= `RTX_BG_COLOR;
    end else if (state == TEST) begin
      // First hit wins, later objects are never looked at
      if (obj_hit) begin
        color <= rd_obj.color;
      end else if (!last_obj) begin
        rd_idx <= rd_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/rtx.sv */
`timescale 1ns/1ns
`default_nettype none

module rtx (
  input  logic                    clk,
  input  logic                    rst_n,
  // Scene load port
  input  logic                    scene_we,
  input  rtx_scene_pkg::obj_idx_t scene_addr,
  input  rtx_scene_pkg::object_t  scene_wdata,
  // Frame control
  input  rtx_scene_pkg::obj_cnt_t num_objs,
  input  logic                    start,
  input  rtx_geom_pkg::vec3_t     cam_pos,
  // Pixel stream
  output logic [15:0]             rtx_pixel,
  output rtx_geom_pkg::pix_h_t    pixel_h,
  output rtx_geom_pkg::pix_v_t    pixel_v,
  output logic                    pixel_valid,
  output logic                    frame_done
);
  import rtx_geom_pkg::*;
  import rtx_scene_pkg::*;

  obj_idx_t rd_idx;
  object_t  rd_obj;
  logic     caster_last;
  logic     tracer_last;
  logic     ray_done;
  rgb888_t  color;
  pix_h_t   trace_h;
  pix_v_t   trace_v;

  // Caster to tracer
  ray_if u_ray_if ();

  // Each finished ray triggers the next one
  ray_caster u_caster (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .next_ray   (ray_done),
    .cam_pos    (cam_pos),
    .frame_last (caster_last),
    .ray        (u_ray_if.caster)
  );

  scene_memory u_scene (
    .clk    (clk),
    .we     (scene_we),
    .waddr  (scene_addr),
    .wdata  (scene_wdata),
    .rd_idx (rd_idx),
    .rd_obj (rd_obj)
  );

  ray_tracer u_tracer (
    .clk            (clk),
    .rst_n          (rst_n),
    .ray            (u_ray_if.tracer),
    .num_objs       (num_objs),
    .rd_idx         (rd_idx),
    .rd_obj         (rd_obj),
    .frame_last_in  (caster_last),
    .ray_done       (ray_done),
    .color          (color),
    .pixel_h_out    (trace_h),
    .pixel_v_out    (trace_v),
    .frame_last_out (tracer_last)
  );

  // RGB565 conversion, one cycle behind ray_done
  pixel_pack u_pack (
    .clk         (clk),
    .rst_n       (rst_n),
    .ray_done    (ray_done),
    .color       (color),
    .pixel_h_in  (trace_h),
    .pixel_v_in  (trace_v),
    .frame_last  (tracer_last),
    .rtx_pixel   (rtx_pixel),
    .pixel_h     (pixel_h),
    .pixel_v     (pixel_v),
    .pixel_valid (pixel_valid),
    .frame_done  (frame_done)
  );

endmodule

`default_nettype wire

/* logic/rtx_geom_pkg.sv */
`include "rtx_params.svh"

package rtx_geom_pkg;

  // One signed fixed-width coordinate
  typedef logic signed [`RTX_COORD_W-1:0] coord_t;

  // Point or direction in camera space
  typedef struct packed {
    coord_t x;
    coord_t y;
    coord_t z;
  } vec3_t;

  // Pixel counters, just wide enough for the frame
  typedef logic [$clog2(`RTX_WIDTH)-1:0]  pix_h_t;
  typedef logic [$clog2(`RTX_HEIGHT)-1:0] pix_v_t;

endpackage

/* logic/rtx_params.svh */
`ifndef RTX_PARAMS_SVH
`define RTX_PARAMS_SVH

// Frame size in pixels
`define RTX_WIDTH 16
`define RTX_HEIGHT 12

// Signed coordinate width for positions, directions and radii
`define RTX_COORD_W 12

// Z component of every primary ray, sets the field of view
`define RTX_FOCAL 16

// Number of object slots in the scene memory
`define RTX_MAX_OBJS 8

// RGB888 colour shown where no object is hit
`define RTX_BG_COLOR 24'h20_40_60

`endif

/* logic/rtx_scene_pkg.sv */
`include "rtx_params.svh"

package rtx_scene_pkg;
  import rtx_geom_pkg::*;

  // 8 bits per channel
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb888_t;

  // Selects how the geometry word is read
  typedef enum logic {
    SPHERE = 1'b0,
    PLANE  = 1'b1
  } obj_kind_t;

  // Centre and radius
  typedef struct packed {
    vec3_t  center;
    coord_t radius;
  } sphere_t;

  // Axis 0 is x, 1 is y, 2 is z; 3 never hits
  typedef struct packed {
    logic [1:0]  axis;
    logic [33:0] pad;
    coord_t      offset;
  } plane_t;

  // Same 48-bit word, decoded by kind
  typedef union packed {
    sphere_t sphere;
    plane_t  plane;
  } geom_u;

  typedef struct packed {
    obj_kind_t kind;
    rgb888_t   color;
    geom_u     geom;
  } object_t;

  // Slot index, and a count that can reach the full capacity
  typedef logic [$clog2(`RTX_MAX_OBJS)-1:0]   obj_idx_t;
  typedef logic [$clog2(`RTX_MAX_OBJS+1)-1:0] obj_cnt_t;

endpackage

/* logic/scene_memory.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rtx_params.svh"

module scene_memory (
  input  logic                   clk,
  input  logic                   we,
  input  rtx_scene_pkg::obj_idx_t waddr,
  input  rtx_scene_pkg::object_t  wdata,
  input  rtx_scene_pkg::obj_idx_t rd_idx,
  output rtx_scene_pkg::object_t  rd_obj
);
  import rtx_scene_pkg::*;

  // Object slots, loaded while the tracer is idle
  object_t mem [`RTX_MAX_OBJS];

  // Write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Read port, data one cycle after the index
  always_ff @(posedge clk) begin
    rd_obj <= mem[rd_idx];
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator, then look for the pass line in the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module rtx_tb \
  -f compile.f -o rtx_sim > build.log 2>&1 &&
  ./obj_dir/rtx_sim > sim.log 2>&1 ||
  echo "Build or simulation returned an error, see build.log and sim.log"
grep -q "^RESULT: PASS$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
